// ==== Makefile ====
# Verilator lint, build and run of the ECG packer testbench
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_ecg_encoder
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The result comes from the log, so a crash without a verdict also fails
sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation gave no verdict"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
logic/ecg_pkg.sv
logic/ecg_data_packer.sv
logic/ecg_tail_packer.sv
logic/ecg_output_stage.sv
logic/ecg_encoder_top.sv
testbench/ecg_encoder_checker.sv
testbench/tb_ecg_encoder.sv

// ==== logic/ecg_data_packer.sv ====
//==========================================================================
// Data part of one ECG: group-skip flag, unary prefix and CPEC or VEC code
// Left-justified in the 50-bit word, with its size in bits
//==========================================================================

`timescale 1ns/10ps

module ecg_data_packer
(
	input  logic                   data_active,		// Group holds coded samples
	input  logic                   group_skip,		// GSF, whole group is zero
	input  ecg_pkg::bits_req_t     bits_req,
	input  ecg_pkg::cpec_code_t    cpec_code,
	input  ecg_pkg::cpec_size_t    cpec_size,
	input  ecg_pkg::vec_prefix_t   vec_prefix,
	input  ecg_pkg::vec_len_t      vec_prefix_size,
	input  ecg_pkg::vec_suffix_t   vec_suffix,
	input  ecg_pkg::vec_len_t      vec_suffix_size,
	output ecg_pkg::ecg_word_t     data_part,
	output ecg_pkg::ecg_size_t     data_size
);

	import ecg_pkg::*;

	//======================================================================
	// Code selection and field offsets
	//======================================================================

	logic      is_cpec;		// bits_req 3 to 9
	logic      is_vec;		// bits_req 1 or 2
	ecg_size_t head_len;		// GSF plus unary prefix
	ecg_size_t suffix_offset;	// Where the VEC suffix starts
	ecg_word_t unary_code;		// bits_req-1 ones then a zero, right aligned
	ecg_word_t unary_field;
	ecg_word_t cpec_field;
	ecg_word_t prefix_field;
	ecg_word_t suffix_field;

	assign is_cpec = (bits_req >= CPEC_MIN_BITS) && (bits_req <= MAX_BITS_REQ);
	assign is_vec  = (bits_req != '0) && (bits_req < CPEC_MIN_BITS);

	assign head_len      = ecg_size_t'(bits_req) + ecg_size_t'(1);
	assign suffix_offset = head_len + ecg_size_t'(vec_prefix_size);

	// 2^n - 2 gives n-1 ones followed by one zero in the low n bits
	assign unary_code = (ecg_word_t'(1) << bits_req) - ecg_word_t'(2);

	// Unary prefix sits right below the GSF at bit 49
	assign unary_field = place_field(unary_code, ecg_size_t'(bits_req), ecg_size_t'(1));

	// Both codes follow the unary prefix directly
	assign cpec_field   = place_field(ecg_word_t'(cpec_code), ecg_size_t'(cpec_size), head_len);
	assign prefix_field = place_field(ecg_word_t'(vec_prefix), ecg_size_t'(vec_prefix_size),
		head_len);
	assign suffix_field = place_field(ecg_word_t'(vec_suffix), ecg_size_t'(vec_suffix_size),
		suffix_offset);	// VEC suffix comes after its prefix

	//======================================================================
	// Data part assembly
	//======================================================================

	always_comb
	begin
		data_part = '0;	// Inactive group and unsupported bits_req stay empty
		data_size = '0;
		if (data_active)
		begin
			if (group_skip)
			begin
				// Skipped group is only the GSF itself
				data_part[ECG_WIDTH-1] = 1'b1;
				data_size = ecg_size_t'(1);
			end
			else if (is_cpec)
			begin
				data_part = unary_field | cpec_field;	// GSF bit stays 0
				data_size = head_len + ecg_size_t'(cpec_size);
			end
			else if (is_vec)
			begin
				data_part = unary_field | prefix_field | suffix_field;
				data_size = suffix_offset + ecg_size_t'(vec_suffix_size);
			end
		end
	end

endmodule

// ==== logic/ecg_encoder_top.sv ====
//==========================================================================
// Top level of the final ECG packing stage
// Data packer and tail packer feed the registered output stage
//==========================================================================

`timescale 1ns/10ps

module ecg_encoder_top
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,		// Group fields valid this cycle
	input  logic                     data_active,
	input  logic                     group_skip,
	input  ecg_pkg::bits_req_t       bits_req,
	input  ecg_pkg::cpec_code_t      cpec_code,
	input  ecg_pkg::cpec_size_t      cpec_size,
	input  ecg_pkg::vec_prefix_t     vec_prefix,
	input  ecg_pkg::vec_len_t        vec_prefix_size,
	input  ecg_pkg::vec_suffix_t     vec_suffix,
	input  ecg_pkg::vec_len_t        vec_suffix_size,
	input  ecg_pkg::ecg_idx_t        ecg_idx,
	input  logic                     component_skip,
	input  logic                     underflow_prevention,
	input  ecg_pkg::stuffing_size_t  stuffing_size,
	input  ecg_pkg::sign_bits_t      sign_bits,
	input  ecg_pkg::sign_size_t      sign_bits_size,
	output ecg_pkg::ecg_word_t       encoded_ecg,
	output ecg_pkg::ecg_size_t       ecg_size,
	output logic                     ecg_valid
);

	import ecg_pkg::*;

	ecg_word_t data_part;
	ecg_size_t data_size;		// Also sets where the tail starts
	ecg_word_t stuffing_part;
	ecg_size_t stuffing_len;
	ecg_word_t sign_part;
	ecg_size_t sign_len;

	//======================================================================
	// Combinational packing of one group
	//======================================================================

	ecg_data_packer u_data_packer
	(
		.data_active     (data_active),
		.group_skip      (group_skip),
		.bits_req        (bits_req),
		.cpec_code       (cpec_code),
		.cpec_size       (cpec_size),
		.vec_prefix      (vec_prefix),
		.vec_prefix_size (vec_prefix_size),
		.vec_suffix      (vec_suffix),
		.vec_suffix_size (vec_suffix_size),
		.data_part       (data_part),
		.data_size       (data_size)
	);

	ecg_tail_packer u_tail_packer
	(
		.ecg_idx              (ecg_idx),
		.component_skip       (component_skip),
		.underflow_prevention (underflow_prevention),
		.stuffing_size        (stuffing_size),
		.sign_bits            (sign_bits),
		.sign_bits_size       (sign_bits_size),
		.data_size            (data_size),
		.stuffing_part        (stuffing_part),
		.stuffing_len         (stuffing_len),
		.sign_part            (sign_part),
		.sign_len             (sign_len)
	);

	// Registered result, one cycle after the strobe
	ecg_output_stage u_output_stage
	(
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.data_part     (data_part),
		.stuffing_part (stuffing_part),
		.sign_part     (sign_part),
		.data_size     (data_size),
		.stuffing_len  (stuffing_len),
		.sign_len      (sign_len),
		.encoded_ecg   (encoded_ecg),
		.ecg_size      (ecg_size),
		.ecg_valid     (ecg_valid)
	);

endmodule

// ==== logic/ecg_output_stage.sv ====
//==========================================================================
// Output register of the ECG packer
// Merges data, stuffing and sign parts and sums their sizes
//==========================================================================

`timescale 1ns/10ps

module ecg_output_stage
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,		// One strobe per group
	input  ecg_pkg::ecg_word_t  data_part,
	input  ecg_pkg::ecg_word_t  stuffing_part,
	input  ecg_pkg::ecg_word_t  sign_part,
	input  ecg_pkg::ecg_size_t  data_size,
	input  ecg_pkg::ecg_size_t  stuffing_len,
	input  ecg_pkg::ecg_size_t  sign_len,
	output ecg_pkg::ecg_word_t  encoded_ecg,
	output ecg_pkg::ecg_size_t  ecg_size,
	output logic                ecg_valid
);

	import ecg_pkg::*;

	ecg_word_t merged_word;
	ecg_size_t total_size;

	// Parts never overlap and absent parts are already zero
	assign merged_word = data_part | stuffing_part | sign_part;
	assign total_size  = data_size + stuffing_len + sign_len;

	//======================================================================
	// One-cycle pipeline register
	//======================================================================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			encoded_ecg <= '0;
			ecg_size    <= '0;
			ecg_valid   <= 1'b0;
		end
		else
		begin
			ecg_valid <= in_valid;	// Pulse follows the strobe by one cycle
			if (in_valid)
			begin
				// Result holds until the next group arrives
				encoded_ecg <= merged_word;
				ecg_size    <= total_size;
			end
		end
	end

endmodule

// ==== logic/ecg_pkg.sv ====
//==========================================================================
// Shared widths, limits and field types of the ECG packer
// Field placement helper used by the data and tail packers
//==========================================================================

package ecg_pkg;

	localparam int ECG_WIDTH         = 50;	// Width of one encoded ECG word
	localparam int SIZE_WIDTH        = 6;	// Every bit count that reaches the output
	localparam int SAMPLES_PER_GROUP = 4;	// Samples carried by one ECG
	localparam int MAX_STUFFING      = 17;	// Largest run of stuffing ones
	localparam int MAX_SIGN_BITS     = 12;	// Width of the sign-bit field

	typedef logic [3:0] bits_req_t;
	typedef logic [1:0] ecg_idx_t;

	localparam bits_req_t CPEC_MIN_BITS = 4'd3;	// From here up the group uses CPEC
	localparam bits_req_t MAX_BITS_REQ  = 4'd9;	// Largest supported bits_req
	localparam ecg_idx_t  LAST_ECG_IDX  = 2'd3;	// Only this ECG carries sign bits

	typedef logic [ECG_WIDTH-1:0] ecg_word_t;
	typedef logic [SIZE_WIDTH-1:0] ecg_size_t;

	// CPEC code is four samples of at most MAX_BITS_REQ bits each
	typedef logic [SAMPLES_PER_GROUP*MAX_BITS_REQ-1:0] cpec_code_t;
	typedef logic [$clog2(SAMPLES_PER_GROUP*MAX_BITS_REQ+1)-1:0] cpec_size_t;

	typedef logic [6:0] vec_prefix_t;
	typedef logic [4:0] vec_suffix_t;
	typedef logic [2:0] vec_len_t;	// Length of a VEC prefix or suffix

	typedef logic [MAX_SIGN_BITS-1:0] sign_bits_t;
	typedef logic [$clog2(MAX_SIGN_BITS+1)-1:0] sign_size_t;
	typedef logic [$clog2(MAX_STUFFING+1)-1:0] stuffing_size_t;

	// Takes the low len bits of value and puts them MSB first into the word,
	// starting offset bits below bit 49. A zero length gives an empty word
	function automatic ecg_word_t place_field(input ecg_word_t value, input ecg_size_t len,
		input ecg_size_t offset);
		ecg_word_t keep;
		keep = ~({ECG_WIDTH{1'b1}} << len);	// Mask of the low len bits
		return ((value & keep) << (ECG_WIDTH - int'(len))) >> offset;
	endfunction

endpackage

// ==== logic/ecg_tail_packer.sv ====
//==========================================================================
// Tail of one ECG: stuffing ones for underflow prevention, then sign bits
// Both parts are placed after the data part, with their lengths
//==========================================================================

`timescale 1ns/10ps

module ecg_tail_packer
(
	input  ecg_pkg::ecg_idx_t        ecg_idx,		// Position of the group in the block
	input  logic                     component_skip,
	input  logic                     underflow_prevention,
	input  ecg_pkg::stuffing_size_t  stuffing_size,
	input  ecg_pkg::sign_bits_t      sign_bits,
	input  ecg_pkg::sign_size_t      sign_bits_size,
	input  ecg_pkg::ecg_size_t       data_size,		// Bits already used by the data part
	output ecg_pkg::ecg_word_t       stuffing_part,
	output ecg_pkg::ecg_size_t       stuffing_len,
	output ecg_pkg::ecg_word_t       sign_part,
	output ecg_pkg::ecg_size_t       sign_len
);

	import ecg_pkg::*;

	logic      stuffing_on;
	logic      sign_on;
	ecg_size_t sign_offset;

	//======================================================================
	// Presence rules
	//======================================================================

	// The first ECG of a block never carries stuffing
	assign stuffing_on = (ecg_idx != '0) && underflow_prevention;

	// Sign bits travel on the last ECG unless the component is skipped
	assign sign_on = (ecg_idx == LAST_ECG_IDX) && !component_skip;

	// An absent part has zero length, so its placed field is empty as well
	assign stuffing_len = stuffing_on ? ecg_size_t'(stuffing_size) : '0;
	assign sign_len     = sign_on ? ecg_size_t'(sign_bits_size) : '0;

	//======================================================================
	// Placement
	//======================================================================

	// Stuffing is a run of ones right after the data part
	assign stuffing_part = place_field({ECG_WIDTH{1'b1}}, stuffing_len, data_size);

	assign sign_offset = data_size + stuffing_len;	// Sign bits close the word

	assign sign_part = place_field(ecg_word_t'(sign_bits), sign_len, sign_offset);

endmodule

// ==== testbench/ecg_encoder_checker.sv ====
//==========================================================================
// Concurrent assertions on the outputs of the ECG packer
// Bound to the top level of the design
//==========================================================================

`timescale 1ns/10ps

module ecg_encoder_checker
(
	input logic               clk,
	input logic               rst_n,
	input logic               in_valid,
	input ecg_pkg::ecg_word_t encoded_ecg,
	input ecg_pkg::ecg_size_t ecg_size,
	input logic               ecg_valid
);

	import ecg_pkg::*;

	int        assert_fails = 0;	// Read by the testbench at the end of the run
	ecg_word_t unused_mask;		// Low bits of the word past the used size

	assign unused_mask = (int'(ecg_size) >= ECG_WIDTH) ? '0 :
		((ecg_word_t'(1) << (ECG_WIDTH - int'(ecg_size))) - ecg_word_t'(1));

	//======================================================================
	// Output assertions
	//======================================================================

	// One result pulse per strobe, exactly one cycle later
	valid_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		ecg_valid == $past(in_valid))
	else
	begin
		$error("ecg_valid is not in_valid delayed by one cycle");
		assert_fails++;
	end

	size_fits_word: assert property (@(posedge clk) disable iff (!rst_n)
		int'(ecg_size) <= ECG_WIDTH)
	else
	begin
		$error("ecg_size is larger than the encoded word");
		assert_fails++;
	end

	// Packing is MSB first, so nothing may sit below the used bits
	unused_bits_zero: assert property (@(posedge clk) disable iff (!rst_n)
		ecg_valid |-> ((encoded_ecg & unused_mask) == '0))
	else
	begin
		$error("encoded_ecg has set bits below its used size");
		assert_fails++;
	end

endmodule

bind ecg_encoder_top ecg_encoder_checker u_checker
(
	.clk         (clk),
	.rst_n       (rst_n),
	.in_valid    (in_valid),
	.encoded_ecg (encoded_ecg),
	.ecg_size    (ecg_size),
	.ecg_valid   (ecg_valid)
);

// ==== testbench/tb_ecg_encoder.sv ====
//==========================================================================
// Testbench of the ECG packer with clock, reset, LCG stimulus, the packing
// model, typed compare tasks and the directed tests
//==========================================================================

`timescale 1ns/10ps

module tb_ecg_encoder;

	import ecg_pkg::*;

	localparam int CLK_PERIOD      = 100;
	localparam int VALID_TIMEOUT   = 20;		// Cycles allowed for one result
	localparam int STREAM_LEN      = 16;		// Groups in the back-to-back burst
	localparam int WATCHDOG_CYCLES = 5000;

	logic           clk;
	logic           rst_n;
	logic           in_valid;
	logic           data_active;
	logic           group_skip;
	bits_req_t      bits_req;
	cpec_code_t     cpec_code;
	cpec_size_t     cpec_size;
	vec_prefix_t    vec_prefix;
	vec_len_t       vec_prefix_size;
	vec_suffix_t    vec_suffix;
	vec_len_t       vec_suffix_size;
	ecg_idx_t       ecg_idx;
	logic           component_skip;
	logic           underflow_prevention;
	stuffing_size_t stuffing_size;
	sign_bits_t     sign_bits;
	sign_size_t     sign_bits_size;
	ecg_word_t      encoded_ecg;
	ecg_size_t      ecg_size;
	logic           ecg_valid;

	int          errors = 0;
	int          checks = 0;
	string       test_name = "none";
	logic [31:0] lcg_state = 32'hf44b12ab;
	ecg_word_t   exp_words[$];		// Oldest result still owed by the DUT sits at the front
	ecg_size_t   exp_sizes[$];

	ecg_encoder_top u_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

	//======================================================================
	// Random numbers and the packing model
	//======================================================================

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = next_rand();
		return lo + (int'({8'd0, r[31:8]}) % (hi - lo + 1));	// High bits are the better ones
	endfunction

	// Appends the low len bits of value MSB first after the used bits
	function automatic void append_bits(inout ecg_word_t word, inout int used,
		input ecg_word_t value, input int len);
		int i;
		for (i = len - 1; i >= 0; i--)
		begin
			if (used < ECG_WIDTH && i < ECG_WIDTH)
				word[ECG_WIDTH-1-used] = value[i];
			used++;
		end
	endfunction

	// Packs the inputs currently driven into the DUT, part after part
	function automatic void model_ecg(output ecg_word_t word, output ecg_size_t size);
		int used;
		word = '0;
		used = 0;
		if (data_active && group_skip)
			append_bits(word, used, ecg_word_t'(1), 1);	// The GSF alone
		else if (data_active && int'(bits_req) >= 1 && int'(bits_req) <= 9)
		begin
			append_bits(word, used, '0, 1);
			append_bits(word, used, {ECG_WIDTH{1'b1}}, int'(bits_req) - 1);
			append_bits(word, used, '0, 1);	// Unary prefix ends in a zero
			if (int'(bits_req) >= 3)
				append_bits(word, used, ecg_word_t'(cpec_code), int'(cpec_size));
			else
			begin
				append_bits(word, used, ecg_word_t'(vec_prefix), int'(vec_prefix_size));
				append_bits(word, used, ecg_word_t'(vec_suffix), int'(vec_suffix_size));
			end
		end
		if (ecg_idx != 2'd0 && underflow_prevention)
			append_bits(word, used, {ECG_WIDTH{1'b1}}, int'(stuffing_size));
		if (ecg_idx == 2'd3 && !component_skip)
			append_bits(word, used, ecg_word_t'(sign_bits), int'(sign_bits_size));
		size = ecg_size_t'(used);
	endfunction

	//======================================================================
	// Compare tasks
	//======================================================================

	task automatic check_word(input string name, input ecg_word_t got, input ecg_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s in %s: got 0x%h, expected 0x%h", name, test_name, got, exp);
		end
	endtask

	task automatic check_size(input string name, input ecg_size_t got, input ecg_size_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s in %s: got 0x%h, expected 0x%h", name, test_name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch %s in %s: got 0x%h, expected 0x%h", name, test_name, got, exp);
		end
	endtask

	//======================================================================
	// Stimulus and result handling
	//======================================================================

	// Drives one group at a rising edge with tail lengths that keep the total within 50
	task automatic drive_group(input int act, input int skip, input int br, input int idx,
		input int ufp, input int cskip, input int pre_len, input int suf_len);
		int data_len;
		int room;
		int stuff_max;
		int stuff_len;
		int sign_len;
		if (act == 0)
			data_len = 0;
		else if (skip != 0)
			data_len = 1;
		else if (br >= 3)
			data_len = 1 + br + SAMPLES_PER_GROUP * br;
		else
			data_len = 1 + br + pre_len + suf_len;
		room = ECG_WIDTH - data_len;	// At least 4 bits stay free for the tail
		// Nonzero tail lengths make a wrongly present part visible in the result
		stuff_max = (room - 1 < MAX_STUFFING) ? room - 1 : MAX_STUFFING;
		stuff_len = rand_range(1, stuff_max);
		room = room - stuff_len;
		sign_len = rand_range(1, (room < MAX_SIGN_BITS) ? room : MAX_SIGN_BITS);
		in_valid             <= 1'b1;
		data_active          <= (act != 0);
		group_skip           <= (skip != 0);
		bits_req             <= bits_req_t'(br);
		cpec_code            <= cpec_code_t'({next_rand(), next_rand()});
		cpec_size            <= cpec_size_t'(SAMPLES_PER_GROUP * br);	// Four samples of br bits
		vec_prefix           <= vec_prefix_t'(next_rand());
		vec_prefix_size      <= vec_len_t'(pre_len);
		vec_suffix           <= vec_suffix_t'(next_rand());
		vec_suffix_size      <= vec_len_t'(suf_len);
		ecg_idx              <= ecg_idx_t'(idx);
		underflow_prevention <= (ufp != 0);
		component_skip       <= (cskip != 0);
		stuffing_size        <= stuffing_size_t'(stuff_len);
		sign_bits            <= sign_bits_t'(next_rand());
		sign_bits_size       <= sign_size_t'(sign_len);
	endtask

	// Samples on falling edges where the registered outputs have settled
	task automatic wait_valid();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!ecg_valid && cycles < VALID_TIMEOUT);
		if (!ecg_valid)
		begin
			errors++;
			$display("Timeout in %s: ecg_valid did not rise within %0d cycles",
				test_name, VALID_TIMEOUT);
		end
	endtask

	// Strobes one group and compares the DUT result with the model
	task automatic run_group(input int act, input int skip, input int br, input int idx,
		input int ufp, input int cskip, input int pre_len, input int suf_len);
		ecg_word_t exp_word;
		ecg_size_t exp_size;
		@(posedge clk);
		drive_group(act, skip, br, idx, ufp, cskip, pre_len, suf_len);
		@(negedge clk);
		model_ecg(exp_word, exp_size);	// Inputs now hold this group
		@(posedge clk);
		in_valid <= 1'b0;
		wait_valid();
		check_word("encoded_ecg", encoded_ecg, exp_word);
		check_size("ecg_size", ecg_size, exp_size);
	endtask

	task automatic check_stream_head();
		check_flag("ecg_valid", ecg_valid, 1'b1);
		check_word("encoded_ecg", encoded_ecg, exp_words.pop_front());
		check_size("ecg_size", ecg_size, exp_sizes.pop_front());
	endtask

	//======================================================================
	// Directed tests
	//======================================================================

	task automatic test_reset_idle();
		test_name = "reset idle";
		check_flag("ecg_valid", ecg_valid, 1'b0);
		check_word("encoded_ecg", encoded_ecg, '0);
		check_size("ecg_size", ecg_size, '0);
	endtask

	task automatic test_cpec();
		test_name = "CPEC packing";
		repeat (24)
			run_group(1, 0, rand_range(3, 9), rand_range(0, 3), rand_range(0, 1),
				rand_range(0, 1), 0, 0);
	endtask

	task automatic test_vec();
		int br;
		int pre;
		int suf;
		test_name = "VEC packing";
		for (br = 1; br <= 2; br++)
			for (pre = 0; pre <= 7; pre++)
				for (suf = 0; suf <= 7; suf++)
					run_group(1, 0, br, rand_range(0, 3), rand_range(0, 1),
						rand_range(0, 1), pre, suf);
	endtask

	task automatic test_group_skip();
		int idx;
		int ufp;
		test_name = "group skip";
		for (idx = 0; idx <= 3; idx++)
			for (ufp = 0; ufp <= 1; ufp++)
			begin
				run_group(1, 1, rand_range(1, 9), idx, ufp, rand_range(0, 1),
					rand_range(0, 7), rand_range(0, 7));
				check_flag("encoded_ecg[49]", encoded_ecg[ECG_WIDTH-1], 1'b1);	// GSF set
			end
	endtask

	task automatic test_tail();
		int idx;
		int ufp;
		int cskip;
		test_name = "tail placement";
		for (idx = 0; idx <= 3; idx++)
			for (ufp = 0; ufp <= 1; ufp++)
				for (cskip = 0; cskip <= 1; cskip++)
					run_group(1, 0, rand_range(1, 9), idx, ufp, cskip,
						rand_range(0, 7), rand_range(0, 7));
	endtask

	task automatic test_inactive();
		test_name = "inactive group";
		run_group(0, 0, rand_range(1, 9), 0, 1, 1, 3, 3);	// First ECG carries no stuffing
		check_word("encoded_ecg", encoded_ecg, '0);
		check_size("ecg_size", ecg_size, '0);
		run_group(0, 1, rand_range(1, 9), 3, 0, 1, 3, 3);	// Last ECG of a skipped component
		check_word("encoded_ecg", encoded_ecg, '0);
		check_size("ecg_size", ecg_size, '0);
	endtask

	// Strobes on every edge and expects each result one cycle behind its group
	task automatic test_streaming();
		ecg_word_t exp_word;
		ecg_size_t exp_size;
		int k;
		test_name = "streaming";
		for (k = 0; k < STREAM_LEN; k++)
		begin
			@(posedge clk);
			drive_group(1, (rand_range(0, 3) == 0), rand_range(1, 9), rand_range(0, 3),
				rand_range(0, 1), rand_range(0, 1), rand_range(0, 7), rand_range(0, 7));
			@(negedge clk);
			if (k > 0)
				check_stream_head();
			model_ecg(exp_word, exp_size);
			exp_words.push_back(exp_word);
			exp_sizes.push_back(exp_size);
		end
		@(posedge clk);
		in_valid <= 1'b0;
		@(negedge clk);
		check_stream_head();
		@(negedge clk);
		check_flag("ecg_valid", ecg_valid, 1'b0);	// No extra result after the burst
	endtask

	//======================================================================
	// Test sequence
	//======================================================================

	initial
	begin
		int assert_count;
		rst_n                <= 1'b0;
		in_valid             <= 1'b0;
		data_active          <= 1'b0;
		group_skip           <= 1'b0;
		bits_req             <= '0;
		cpec_code            <= '0;
		cpec_size            <= '0;
		vec_prefix           <= '0;
		vec_prefix_size      <= '0;
		vec_suffix           <= '0;
		vec_suffix_size      <= '0;
		ecg_idx              <= '0;
		component_skip       <= 1'b0;
		underflow_prevention <= 1'b0;
		stuffing_size        <= '0;
		sign_bits            <= '0;
		sign_bits_size       <= '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		test_reset_idle();
		test_cpec();
		test_vec();
		test_group_skip();
		test_tail();
		test_inactive();
		test_streaming();
		@(negedge clk);
		assert_count = u_dut.u_checker.assert_fails;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assert_count);
		if (errors == 0 && assert_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
